// File: rtl/screenPkg.sv
package screenPkg;

	// Playing field
	localparam int ScreenWidth = 320;
	localparam int ScreenHeight = 240;
	localparam int TrackDepth = ScreenWidth * ScreenHeight;

	// Sixteen orientations of 32 by 32 pixels in the atlas
	localparam int SpriteSize = 32;
	localparam int SpriteCount = 16;
	localparam int AtlasDepth = SpriteCount * SpriteSize * SpriteSize;

	typedef logic [8:0] xCoordT;
	typedef logic [7:0] yCoordT;

	// 2 bits per channel
	typedef logic [5:0] colourT;

	typedef logic [16:0] trackAddressT;
	typedef logic [13:0] spriteAddressT;

	// Purple in the atlas means the track shows through
	localparam colourT TransparentColour = 6'b100010;

	// Green on the track is wall
	localparam colourT WallColour = 6'b001100;

endpackage

// File: rtl/racePkg.sv
package racePkg;

	// Counterclockwise from right, so a left turn adds one
	typedef enum logic [3:0] {
		OrientRight,
		OrientUpRightRight,
		OrientUpRight,
		OrientUpUpRight,
		OrientUp,
		OrientUpUpLeft,
		OrientUpLeft,
		OrientUpLeftLeft,
		OrientLeft,
		OrientDownLeftLeft,
		OrientDownLeft,
		OrientDownDownLeft,
		OrientDown,
		OrientDownDownRight,
		OrientDownRight,
		OrientDownRightRight
	} orientationT;

	localparam int PixelsToMove = 2;

	localparam screenPkg::xCoordT StartX = 9'd126;
	localparam screenPkg::yCoordT StartY = 8'd197;

	localparam screenPkg::xCoordT StartLineX = 9'd164;
	localparam screenPkg::xCoordT FinishLineX = 9'd126;

	// Exclusive on both sides
	localparam screenPkg::yCoordT LineWindowLow = 8'd183;
	localparam screenPkg::yCoordT LineWindowHigh = 8'd206;

	// X component of a forward step; the y component is this one a quarter turn back
	function automatic logic signed [3:0] axisStep(input logic [3:0] direction);
		case (direction)
			4'd0, 4'd1, 4'd2, 4'd14, 4'd15: axisStep = 4'(PixelsToMove);
			4'd3, 4'd13: axisStep = 4'(PixelsToMove - 1);
			4'd4, 4'd12: axisStep = 4'sd0;
			4'd5, 4'd11: axisStep = -4'(PixelsToMove - 1);
			default: axisStep = -4'(PixelsToMove);
		endcase
	endfunction

endpackage

// File: rtl/pixelIf.sv
interface pixelIf;

	logic valid;
	logic [8:0] x;
	logic [7:0] y;
	logic [5:0] colour;

	modport source (
		output valid, x, y, colour
	);

	modport sink (
		input valid, x, y, colour
	);

endinterface

// File: rtl/videoMemory.sv
module videoMemory #(
	parameter int Depth = 76800,
	parameter int AddressWidth = 17
) (
	input logic Clock,
	input logic writeEnable,
	input logic [AddressWidth-1:0] writeAddress,
	input screenPkg::colourT writeData,
	input logic [AddressWidth-1:0] readAddress,
	output screenPkg::colourT readData
);

	import screenPkg::*;

	colourT memory [Depth];

	// Load port from the host
	always_ff @(posedge Clock) begin
		if (writeEnable) begin
			memory[writeAddress] <= writeData;
		end
	end

	// Data comes back one clock after the address
	always_ff @(posedge Clock) begin
		readData <= memory[readAddress];
	end

endmodule

// File: rtl/backgroundPainter.sv
module backgroundPainter (
	input logic Clock,
	input logic set_reset_signals,
	input logic request,
	input logic move,
	output logic trackRead,
	output screenPkg::trackAddressT trackAddress,
	input screenPkg::colourT trackColour,
	pixelIf.source pixel,
	output logic done
);

	import screenPkg::*;

	xCoordT x;
	yCoordT y;
	xCoordT xDelayed;
	yCoordT yDelayed;
	logic validDelayed;
	logic scanOver;
	logic lastPixel;
	logic lastDelayed;
	logic lastDelayedTwice;

	assign trackRead = request && !done && !scanOver;
	assign trackAddress = trackAddressT'(y * ScreenWidth + x);
	assign lastPixel = x == xCoordT'(ScreenWidth - 1) && y == yCoordT'(ScreenHeight - 1);

	always_ff @(posedge Clock) begin
		if (set_reset_signals || move) begin
			x <= '0;
			y <= '0;
			scanOver <= 1'b0;
			done <= 1'b0;
		end else begin
			if (trackRead) begin
				if (lastPixel) begin
					x <= '0;
					y <= '0;
					scanOver <= 1'b1;
				end else if (x == xCoordT'(ScreenWidth - 1)) begin
					x <= '0;
					y <= y + 8'd1;
				end else begin
					x <= x + 9'd1;
				end
			end
			// Last beat leaves the arbiter two cycles after its address
			if (lastDelayedTwice) begin
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (set_reset_signals) begin
			validDelayed <= 1'b0;
			lastDelayed <= 1'b0;
			lastDelayedTwice <= 1'b0;
		end else begin
			validDelayed <= trackRead;
			lastDelayed <= trackRead && lastPixel;
			lastDelayedTwice <= lastDelayed;
		end
	end

	// Coordinates follow the memory latency
	always_ff @(posedge Clock) begin
		xDelayed <= x;
		yDelayed <= y;
	end

	assign pixel.valid = validDelayed;
	assign pixel.x = xDelayed;
	assign pixel.y = yDelayed;
	assign pixel.colour = trackColour;

endmodule

// File: rtl/carPainter.sv
module carPainter (
	input logic Clock,
	input logic set_reset_signals,
	input logic request,
	input logic move,
	input screenPkg::xCoordT carX,
	input screenPkg::yCoordT carY,
	input racePkg::orientationT orientation,
	output screenPkg::spriteAddressT spriteAddress,
	input screenPkg::colourT spriteColour,
	output logic trackRead,
	output screenPkg::trackAddressT trackAddress,
	input screenPkg::colourT trackColour,
	pixelIf.source pixel,
	output logic done,
	output logic hitWall
);

	import screenPkg::*;

	logic [4:0] offsetX;
	logic [4:0] offsetY;
	xCoordT scanX;
	yCoordT scanY;
	xCoordT xDelayed;
	yCoordT yDelayed;
	logic validDelayed;
	logic lastDelayed;
	logic scanOver;
	logic lastOffset;
	logic visible;
	logic collision;

	assign trackRead = request && !done && !scanOver;
	assign scanX = carX + xCoordT'(offsetX);
	assign scanY = carY + yCoordT'(offsetY);
	assign trackAddress = trackAddressT'(scanY * ScreenWidth + scanX);
	// Block of the orientation, then row and column inside it
	assign spriteAddress = spriteAddressT'({orientation, offsetY, offsetX});
	assign lastOffset = offsetX == 5'(SpriteSize - 1) && offsetY == 5'(SpriteSize - 1);

	assign visible = spriteColour != TransparentColour;
	assign collision = validDelayed && visible && trackColour == WallColour;

	always_ff @(posedge Clock) begin
		if (set_reset_signals || move) begin
			offsetX <= '0;
			offsetY <= '0;
			scanOver <= 1'b0;
			done <= 1'b0;
		end else begin
			if (trackRead) begin
				// Column wraps by itself at 31
				offsetX <= offsetX + 5'd1;
				if (offsetX == 5'(SpriteSize - 1)) begin
					offsetY <= offsetY + 5'd1;
				end
				if (lastOffset) begin
					scanOver <= 1'b1;
				end
			end
			if (collision || lastDelayed) begin
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (set_reset_signals) begin
			validDelayed <= 1'b0;
			lastDelayed <= 1'b0;
			hitWall <= 1'b0;
		end else begin
			// A read issued alongside a crash never becomes a beat
			validDelayed <= trackRead && !collision;
			lastDelayed <= trackRead && lastOffset;
			if (collision) begin
				hitWall <= 1'b1;
			end
		end
	end

	always_ff @(posedge Clock) begin
		xDelayed <= scanX;
		yDelayed <= scanY;
	end

	assign pixel.valid = validDelayed;
	assign pixel.x = xDelayed;
	assign pixel.y = yDelayed;
	assign pixel.colour = visible ? spriteColour : trackColour;

endmodule

// File: rtl/carSteering.sv
module carSteering (
	input logic Clock,
	input logic set_reset_signals,
	input logic move,
	input logic startRace,
	input logic moveForward,
	input logic moveRight,
	input logic moveLeft,
	output screenPkg::xCoordT carX,
	output screenPkg::yCoordT carY,
	output racePkg::orientationT orientation
);

	import screenPkg::*;
	import racePkg::*;

	xCoordT stepX;
	yCoordT stepY;

	// Two's complement steps, y grows downward
	assign stepX = xCoordT'(axisStep(orientation));
	assign stepY = yCoordT'(-axisStep(orientation - 4'd4));

	always_ff @(posedge Clock) begin
		if (set_reset_signals || startRace) begin
			orientation <= OrientRight;
			carX <= StartX;
			carY <= StartY;
		end else if (move) begin
			if (moveForward) begin
				carX <= carX + stepX;
				carY <= carY + stepY;
			end else if (moveRight) begin
				// Clockwise
				orientation <= orientationT'(orientation - 4'd1);
			end else if (moveLeft) begin
				orientation <= orientationT'(orientation + 4'd1);
			end
		end
	end

endmodule

// File: rtl/lapMonitor.sv
module lapMonitor (
	input logic Clock,
	input logic set_reset_signals,
	input logic startRace,
	input screenPkg::xCoordT carX,
	input screenPkg::yCoordT carY,
	output logic finishedRace
);

	import racePkg::*;

	logic pastStartLine;
	logic inWindow;

	assign inWindow = carY > LineWindowLow && carY < LineWindowHigh;

	always_ff @(posedge Clock) begin
		if (set_reset_signals) begin
			finishedRace <= 1'b1;
			pastStartLine <= 1'b0;
		end else if (startRace) begin
			finishedRace <= 1'b0;
			pastStartLine <= 1'b0;
		end else begin
			if (carX == StartLineX && inWindow) begin
				pastStartLine <= 1'b1;
			end
			// Back over the finish line after the start line
			if (!finishedRace && pastStartLine && carX == FinishLineX && inWindow) begin
				finishedRace <= 1'b1;
			end
		end
	end

endmodule

// File: rtl/plotArbiter.sv
module plotArbiter (
	input logic Clock,
	input logic set_reset_signals,
	pixelIf.sink backgroundPixel,
	pixelIf.sink carPixel,
	input logic backgroundRead,
	input screenPkg::trackAddressT backgroundAddress,
	input logic carRead,
	input screenPkg::trackAddressT carAddress,
	output screenPkg::trackAddressT trackReadAddress,
	output logic pixelValid,
	output screenPkg::xCoordT xOut,
	output screenPkg::yCoordT yOut,
	output screenPkg::colourT colourOut
);

	// Background wins the shared port
	assign trackReadAddress = backgroundRead ? backgroundAddress : (carRead ? carAddress : '0);

	always_ff @(posedge Clock) begin
		if (set_reset_signals) begin
			pixelValid <= 1'b0;
		end else begin
			pixelValid <= backgroundPixel.valid || carPixel.valid;
		end
	end

	always_ff @(posedge Clock) begin
		if (backgroundPixel.valid) begin
			xOut <= backgroundPixel.x;
			yOut <= backgroundPixel.y;
			colourOut <= backgroundPixel.colour;
		end else if (carPixel.valid) begin
			xOut <= carPixel.x;
			yOut <= carPixel.y;
			colourOut <= carPixel.colour;
		end
	end

endmodule

// File: rtl/raceTop.sv
module raceTop (
	input logic Clock,
	input logic set_reset_signals,
	input logic drawBackground,
	input logic drawCar,
	input logic move,
	input logic startRace,
	input logic moveForward,
	input logic moveRight,
	input logic moveLeft,
	input logic loadValid,
	input logic loadTrack,
	input screenPkg::trackAddressT loadAddress,
	input screenPkg::colourT loadData,
	output logic pixelValid,
	output screenPkg::xCoordT xOut,
	output screenPkg::yCoordT yOut,
	output screenPkg::colourT colourOut,
	output logic doneBackground,
	output logic doneCar,
	output logic hitWall,
	output logic finishedRace
);

	import screenPkg::*;
	import racePkg::*;

	logic backgroundRead;
	logic carRead;
	trackAddressT backgroundAddress;
	trackAddressT carTrackAddress;
	trackAddressT trackReadAddress;
	colourT trackColour;
	spriteAddressT spriteAddress;
	colourT spriteColour;
	xCoordT carX;
	yCoordT carY;
	orientationT orientation;

	pixelIf backgroundPixel ();
	pixelIf carPixel ();

	videoMemory #(
		.Depth(TrackDepth),
		.AddressWidth($bits(trackAddressT))
	) i_trackMemory (
		.Clock(Clock),
		.writeEnable(loadValid && loadTrack),
		.writeAddress(loadAddress),
		.writeData(loadData),
		.readAddress(trackReadAddress),
		.readData(trackColour)
	);

	videoMemory #(
		.Depth(AtlasDepth),
		.AddressWidth($bits(spriteAddressT))
	) i_atlasMemory (
		.Clock(Clock),
		.writeEnable(loadValid && !loadTrack),
		.writeAddress(loadAddress[$bits(spriteAddressT)-1:0]),
		.writeData(loadData),
		.readAddress(spriteAddress),
		.readData(spriteColour)
	);

	backgroundPainter i_backgroundPainter (
		.Clock(Clock),
		.set_reset_signals(set_reset_signals),
		.request(drawBackground),
		.move(move),
		.trackRead(backgroundRead),
		.trackAddress(backgroundAddress),
		.trackColour(trackColour),
		.pixel(backgroundPixel.source),
		.done(doneBackground)
	);

	carPainter i_carPainter (
		.Clock(Clock),
		.set_reset_signals(set_reset_signals),
		.request(drawCar),
		.move(move),
		.carX(carX),
		.carY(carY),
		.orientation(orientation),
		.spriteAddress(spriteAddress),
		.spriteColour(spriteColour),
		.trackRead(carRead),
		.trackAddress(carTrackAddress),
		.trackColour(trackColour),
		.pixel(carPixel.source),
		.done(doneCar),
		.hitWall(hitWall)
	);

	carSteering i_carSteering (
		.Clock(Clock),
		.set_reset_signals(set_reset_signals),
		.move(move),
		.startRace(startRace),
		.moveForward(moveForward),
		.moveRight(moveRight),
		.moveLeft(moveLeft),
		.carX(carX),
		.carY(carY),
		.orientation(orientation)
	);

	lapMonitor i_lapMonitor (
		.Clock(Clock),
		.set_reset_signals(set_reset_signals),
		.startRace(startRace),
		.carX(carX),
		.carY(carY),
		.finishedRace(finishedRace)
	);

	plotArbiter i_plotArbiter (
		.Clock(Clock),
		.set_reset_signals(set_reset_signals),
		.backgroundPixel(backgroundPixel.sink),
		.carPixel(carPixel.sink),
		.backgroundRead(backgroundRead),
		.backgroundAddress(backgroundAddress),
		.carRead(carRead),
		.carAddress(carTrackAddress),
		.trackReadAddress(trackReadAddress),
		.pixelValid(pixelValid),
		.xOut(xOut),
		.yOut(yOut),
		.colourOut(colourOut)
	);

endmodule

// File: verif/raceTb.sv
module raceTb;

	timeunit 1ns;
	timeprecision 1ps;

	import screenPkg::*;
	import racePkg::*;

	localparam int TestCount = 5;
	localparam int CyclesPerTest = 120000;
	localparam int WallLeft = 200;
	localparam int WallRight = 203;
	localparam int WallTop = 190;
	localparam int WallBottom = 235;

	logic Clock;
	logic set_reset_signals;
	logic drawBackground;
	logic drawCar;
	logic move;
	logic startRace;
	logic moveForward;
	logic moveRight;
	logic moveLeft;
	logic loadValid;
	logic loadTrack;
	trackAddressT loadAddress;
	colourT loadData;
	logic pixelValid;
	xCoordT xOut;
	yCoordT yOut;
	colourT colourOut;
	logic doneBackground;
	logic doneCar;
	logic hitWall;
	logic finishedRace;

	// Reference copies of both memories and the car state
	colourT trackRef [TrackDepth];
	colourT atlasRef [AtlasDepth];
	int refX;
	int refY;
	int refOrient;
	// Forward step per orientation counterclockwise from right with y growing downward
	int stepX [16] = '{2, 2, 2, 1, 0, -1, -2, -2, -2, -2, -2, -1, 0, 1, 2, 2};
	int stepY [16] = '{0, -1, -2, -2, -2, -2, -2, -1, 0, 1, 2, 2, 2, 2, 2, 1};

	int expX[$];
	int expY[$];
	int expColour[$];
	int beatX[$];
	int beatY[$];
	int beatColour[$];

	logic [31:0] rngState;
	string testName = "init";
	int errorCount = 0;
	int testErrorBase = 0;
	int testsRun = 0;
	int testsFailed = 0;

	raceTop i_raceTop (.*);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	initial begin
		repeat (TestCount * CyclesPerTest) @(posedge Clock);
		$display("Watchdog expired in test %s, the run did not finish in time", testName);
		$display("SIMULATION FAILED");
		$finish;
	end

	assert property (@(posedge Clock) disable iff (set_reset_signals)
		$rose(hitWall) |-> doneCar)
	else begin
		errorCount++;
		$display("hitWall rose without doneCar in test %s", testName);
	end

	// The last background beat comes one cycle before done
	assert property (@(posedge Clock) disable iff (set_reset_signals)
		$rose(doneBackground) |-> $past(pixelValid) && !pixelValid)
	else begin
		errorCount++;
		$display("doneBackground rose out of step with the last beat in test %s", testName);
	end

	assert property (@(posedge Clock) disable iff (set_reset_signals)
		$past(doneCar) && doneCar |-> !pixelValid)
	else begin
		errorCount++;
		$display("A beat followed the end of the car draw in test %s", testName);
	end

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] next;
		next = state ^ (state << 13);
		next = next ^ (next >> 17);
		next = next ^ (next << 5);
		return next;
	endfunction

	function automatic colourT blockColour(input int block);
		return colourT'(40 + block);
	endfunction

	task automatic checkValue(input string what, input int expected, input int actual);
		assert (actual == expected) else begin
			errorCount++;
			if (errorCount - testErrorBase <= 10) begin
				$display("ERR %s %s expected %0d actual %0d", testName, what, expected, actual);
			end
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrorBase = errorCount;
	endtask

	task automatic finishTest();
		testsRun++;
		if (errorCount == testErrorBase) begin
			$display("Test %s passed", testName);
		end else begin
			testsFailed++;
			$display("Test %s failed with %0d errors", testName, errorCount - testErrorBase);
		end
	endtask

	task automatic fillReference();
		colourT value;
		int column;
		int row;
		for (int a = 0; a < TrackDepth; a++) begin
			rngState = xorshift(rngState);
			value = rngState[5:0];
			if (value == WallColour) value = value ^ 6'b000001;
			column = a % ScreenWidth;
			row = a / ScreenWidth;
			if (column >= WallLeft && column <= WallRight && row >= WallTop && row <= WallBottom) begin
				value = WallColour;
			end
			trackRef[a] = value;
		end
		for (int a = 0; a < AtlasDepth; a++) begin
			rngState = xorshift(rngState);
			value = rngState[5:0];
			if (value == TransparentColour) value = value ^ 6'b000001;
			if (a % (SpriteSize * SpriteSize) == 0) value = blockColour(a / (SpriteSize * SpriteSize));
			if (a % SpriteSize == 5) value = TransparentColour;
			atlasRef[a] = value;
		end
	endtask

	task automatic loadMemories();
		for (int a = 0; a < TrackDepth + AtlasDepth; a++) begin
			@(negedge Clock);
			loadValid = 1'b1;
			loadTrack = a < TrackDepth;
			loadAddress = trackAddressT'(a < TrackDepth ? a : a - TrackDepth);
			loadData = a < TrackDepth ? trackRef[a] : atlasRef[a - TrackDepth];
		end
		@(negedge Clock);
		loadValid = 1'b0;
	endtask

	task automatic applyReset();
		set_reset_signals = 1'b1;
		repeat (2) @(negedge Clock);
		set_reset_signals = 1'b0;
		refX = int'(StartX);
		refY = int'(StartY);
		refOrient = 0;
	endtask

	task automatic pulseMove(input logic forward, input logic right, input logic left);
		@(negedge Clock);
		move = 1'b1;
		moveForward = forward;
		moveRight = right;
		moveLeft = left;
		@(negedge Clock);
		move = 1'b0;
		moveForward = 1'b0;
		moveRight = 1'b0;
		moveLeft = 1'b0;
		if (forward) begin
			refX = refX + stepX[refOrient];
			refY = refY + stepY[refOrient];
		end else if (right) begin
			refOrient = (refOrient + 15) % 16;
		end else if (left) begin
			refOrient = (refOrient + 1) % 16;
		end
	endtask

	task automatic pulseStart();
		@(negedge Clock);
		startRace = 1'b1;
		@(negedge Clock);
		startRace = 1'b0;
		refX = int'(StartX);
		refY = int'(StartY);
		refOrient = 0;
	endtask

	// Holds the request until done and records every beat on the way
	task automatic collectBeats(input logic car);
		logic finished;
		finished = 1'b0;
		beatX.delete();
		beatY.delete();
		beatColour.delete();
		@(negedge Clock);
		drawCar = car;
		drawBackground = !car;
		while (!finished) begin
			@(negedge Clock);
			if (pixelValid) begin
				beatX.push_back(int'(xOut));
				beatY.push_back(int'(yOut));
				beatColour.push_back(int'(colourOut));
			end
			finished = car ? doneCar : doneBackground;
		end
		drawCar = 1'b0;
		drawBackground = 1'b0;
	endtask

	task automatic compareBeats();
		int count;
		checkValue("beat count", expX.size(), beatX.size());
		count = beatX.size() < expX.size() ? beatX.size() : expX.size();
		for (int k = 0; k < count; k++) begin
			checkValue("beat x", expX[k], beatX[k]);
			checkValue("beat y", expY[k], beatY[k]);
			checkValue("beat colour", expColour[k], beatColour[k]);
		end
	endtask

	task automatic checkCarDraw();
		logic expectHit;
		int px;
		int py;
		colourT sprite;
		colourT track;
		expectHit = 1'b0;
		expX.delete();
		expY.delete();
		expColour.delete();
		for (int k = 0; k < SpriteSize * SpriteSize && !expectHit; k++) begin
			px = refX + k % SpriteSize;
			py = refY + k / SpriteSize;
			sprite = atlasRef[refOrient * SpriteSize * SpriteSize + k];
			track = trackRef[py * ScreenWidth + px];
			expX.push_back(px);
			expY.push_back(py);
			expColour.push_back(int'(sprite == TransparentColour ? track : sprite));
			// Scan stops on the first visible pixel over wall
			if (sprite != TransparentColour && track == WallColour) expectHit = 1'b1;
		end
		collectBeats(1'b1);
		compareBeats();
		checkValue("hitWall", int'(expectHit), int'(hitWall));
	endtask

	initial begin
		set_reset_signals = 1'b1;
		drawBackground = 1'b0;
		drawCar = 1'b0;
		move = 1'b0;
		startRace = 1'b0;
		moveForward = 1'b0;
		moveRight = 1'b0;
		moveLeft = 1'b0;
		loadValid = 1'b0;
		loadTrack = 1'b0;
		loadAddress = '0;
		loadData = '0;
		rngState = 32'd86545;
		fillReference();
		applyReset();
		loadMemories();

		startTest("background");
		expX.delete();
		expY.delete();
		expColour.delete();
		for (int a = 0; a < TrackDepth; a++) begin
			expX.push_back(a % ScreenWidth);
			expY.push_back(a / ScreenWidth);
			expColour.push_back(int'(trackRef[a]));
		end
		collectBeats(1'b0);
		compareBeats();
		repeat (3) @(negedge Clock);
		checkValue("doneBackground held", 1, int'(doneBackground));
		pulseMove(1'b0, 1'b0, 1'b0);
		checkValue("doneBackground after move", 0, int'(doneBackground));
		finishTest();

		startTest("carAtStart");
		checkCarDraw();
		finishTest();

		startTest("steering");
		pulseMove(1'b0, 1'b0, 1'b1);
		pulseMove(1'b1, 1'b0, 1'b0);
		checkCarDraw();
		if (beatX.size() != 0) begin
			checkValue("first beat x", 128, beatX[0]);
			checkValue("first beat y", 196, beatY[0]);
			checkValue("first beat colour", int'(blockColour(1)), beatColour[0]);
		end
		repeat (3) pulseMove(1'b0, 1'b1, 1'b0);
		checkCarDraw();
		if (beatX.size() != 0) begin
			checkValue("first beat colour", int'(blockColour(14)), beatColour[0]);
		end
		finishTest();

		startTest("collision");
		pulseStart();
		repeat (22) pulseMove(1'b1, 1'b0, 1'b0);
		checkCarDraw();
		checkValue("hitWall", 1, int'(hitWall));
		if (beatX.size() != 0) begin
			checkValue("last beat x", WallLeft, beatX[beatX.size() - 1]);
		end
		repeat (2) @(negedge Clock);
		checkValue("doneCar held", 1, int'(doneCar));
		finishTest();

		startTest("lap");
		applyReset();
		checkValue("finishedRace after reset", 1, int'(finishedRace));
		pulseStart();
		checkValue("finishedRace after start", 0, int'(finishedRace));
		repeat (19) begin
			pulseMove(1'b1, 1'b0, 1'b0);
			checkValue("finishedRace outbound", 0, int'(finishedRace));
		end
		repeat (8) pulseMove(1'b0, 1'b0, 1'b1);
		repeat (19) begin
			pulseMove(1'b1, 1'b0, 1'b0);
			checkValue("finishedRace inbound", 0, int'(finishedRace));
		end
		@(negedge Clock);
		checkValue("finishedRace at finish line", 1, int'(finishedRace));
		finishTest();

		$display("Tests run %0d, passed %0d, failed %0d, errors %0d",
			testsRun, testsRun - testsFailed, testsFailed, errorCount);
		if (errorCount == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: all.f
rtl/screenPkg.sv
rtl/racePkg.sv
rtl/pixelIf.sv
rtl/videoMemory.sv
rtl/backgroundPainter.sv
rtl/carPainter.sv
rtl/carSteering.sv
rtl/lapMonitor.sv
rtl/plotArbiter.sv
rtl/raceTop.sv
verif/raceTb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then look for the failure line in the log
verilator --binary --assert --timescale 1ns/1ps --top-module raceTb -f all.f -o raceSim \
	> build.log 2>&1 \
	&& ./obj_dir/raceSim > sim.log 2>&1 \
	|| { echo "Build or run error, see build.log and sim.log"; exit 1; }
grep -q "SIMULATION FAILED" sim.log && { echo "Failure reported in sim.log"; exit 1; } \
	|| { echo "No failure reported in sim.log"; exit 0; }
